// ==== agc_loop.f ====
design/agc_loop_pkg.sv
design/agc_step_calc.sv
design/agc_wb_master.sv
design/agc_sequencer.sv
design/agc_status_slave.sv
design/agc_loop_top.sv
dv/agc_loop_tb.sv

// ==== dv/agc_loop_tb.sv ====
`timescale 1ns/1ps

module agc_loop_tb import agc_loop_pkg::*; ();

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_LOOPS   = 40;
    localparam int RESET_LOOP  = 20;                // Loop that gets cut by agc_reset_i
    localparam int XFER_CYCLES = 9;                 // Ack delay, ack and handshake gap
    localparam int LOOP_CYCLES = 16 * XFER_CYCLES + 12 * 3;
    localparam int BOOT_CYCLES = BOOT_DELAY + 3 + 4 * XFER_CYCLES;
    localparam int RUN_CYCLES  = (NUM_LOOPS + 2) * LOOP_CYCLES + 2 * BOOT_CYCLES + 8;

    logic                aclk = 1'b0;
    logic                wb_rst_i;
    logic                agc_reset_i;
    logic                wb_ctl_cyc_i;
    logic                wb_ctl_stb_i;
    logic                wb_ctl_we_i;
    logic [WB_ADR_W-1:0] wb_ctl_adr_i;
    logic [WB_DAT_W-1:0] wb_ctl_dat_i;
    logic                wb_ctl_ack_o;
    logic [WB_DAT_W-1:0] wb_ctl_dat_o;
    logic                wb_agc_cyc_o;
    logic                wb_agc_stb_o;
    logic                wb_agc_we_o;
    logic [WB_ADR_W-1:0] wb_agc_adr_o;
    logic [WB_DAT_W-1:0] wb_agc_dat_o;
    logic                wb_agc_ack_i;
    logic [WB_DAT_W-1:0] wb_agc_dat_i;

    logic [15:0]         lfsr;
    int                  errors    = 0;
    int                  transfers = 0;
    int                  loops     = 0;
    int                  hits [8];                  // Scale down, up, min hold, max hold, hold,
                                                    // then offset down, up, hold
    logic [WB_DAT_W-1:0] dp_scale;                  // Datapath model registers
    logic [WB_DAT_W-1:0] dp_offset;
    logic [WB_DAT_W-1:0] exp_info [INFO_WORDS];

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    agc_loop_top DUT (.*);

    ////////////////////////////////////////////////////////////
    // Random source and reference step rules
    ////////////////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [SCALE_W-1:0] model_scale(input logic [31:0] ms,
                                                       input logic [31:0] sw);
        logic [31:0]        level;
        logic [SCALE_W-1:0] cur;
        level = ms >> RMS_SHIFT;
        cur   = sw[SCALE_W-1:0];
        if (level > TARGET_RMS_SQ + RMS_SQ_ERR) begin
            hits[cur > SCALE_MIN ? 0 : 2]++;
            return (cur > SCALE_MIN) ? cur - SCALE_STEP : cur;
        end
        if (level < TARGET_RMS_SQ - RMS_SQ_ERR) begin
            hits[cur < SCALE_MAX ? 1 : 3]++;
            return (cur < SCALE_MAX) ? cur + SCALE_STEP : cur;
        end
        hits[4]++;
        return cur;
    endfunction

    function automatic logic [OFFSET_W-1:0] model_offset(input logic [31:0] above,
                                                         input logic [31:0] below,
                                                         input logic [31:0] ow);
        logic [OFFSET_W-1:0] cur;
        cur = ow[OFFSET_W-1:0];                     // 16-bit wrap
        if (above > below + OFFSET_ERR) begin
            hits[5]++;
            return cur - OFFSET_STEP;
        end
        if (below > above + OFFSET_ERR) begin
            hits[6]++;
            return cur + OFFSET_STEP;
        end
        hits[7]++;
        return cur;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    endtask

    ////////////////////////////////////////////////////////////
    // AGC datapath model on the master port
    ////////////////////////////////////////////////////////////
    task automatic serve_transfer(input string name, input logic we,
                                  input logic [WB_ADR_W-1:0] adr,
                                  input logic [WB_DAT_W-1:0] wdat,
                                  input logic [WB_DAT_W-1:0] rdat);
        logic                we_seen;
        logic [WB_ADR_W-1:0] adr_seen;
        logic [WB_DAT_W-1:0] dat_seen;
        logic [31:0]         delay;
        while (wb_agc_stb_o !== 1'b1) @(negedge aclk);
        we_seen  = wb_agc_we_o;
        adr_seen = wb_agc_adr_o;
        dat_seen = wb_agc_dat_o;
        transfers++;
        if (we_seen !== we) report_mismatch({name, " we"}, 32'(we), 32'(we_seen));
        if (adr_seen !== adr) report_mismatch({name, " adr"}, 32'(adr), 32'(adr_seen));
        if (we && dat_seen !== wdat) report_mismatch({name, " data"}, wdat, dat_seen);
        delay = rand_bits(2);                       // Back-pressure of 0 to 3 cycles
        repeat (delay) begin
            @(negedge aclk);
            if (wb_agc_stb_o !== 1'b1 || wb_agc_cyc_o !== 1'b1 || wb_agc_we_o !== we_seen
                || wb_agc_adr_o !== adr_seen || wb_agc_dat_o !== dat_seen) begin
                errors++;
                $display("%s: bus request dropped or changed before ack", name);
            end
        end
        wb_agc_ack_i = 1'b1;
        wb_agc_dat_i = rdat;
        @(negedge aclk);
        wb_agc_ack_i = 1'b0;
        wb_agc_dat_i = '0;
        if (wb_agc_stb_o !== 1'b0 || wb_agc_cyc_o !== 1'b0) begin
            errors++;
            $display("%s: cyc or stb still high after the ack edge", name);
        end
    endtask

    // Called on the falling edge that releases a reset
    task automatic check_boot_delay();
        int n;
        n = 0;
        while (wb_agc_stb_o !== 1'b1 && n < 4 * BOOT_DELAY) begin
            @(negedge aclk);
            n++;
        end
        // Boot delay, request pulse, then cyc on the next edge
        if (n != BOOT_DELAY + 3) report_mismatch("boot_delay", BOOT_DELAY + 3, n);
    endtask

    task automatic serve_start_values();
        check_boot_delay();
        serve_transfer("start_scale", 1'b1, ADR_SCALE, 32'(START_SCALE), '0);
        serve_transfer("start_offset", 1'b1, ADR_OFFSET, 32'(START_OFFSET), '0);
        serve_transfer("start_load", 1'b1, ADR_CTRL, CMD_LOAD, '0);
        serve_transfer("start_apply", 1'b1, ADR_CTRL, CMD_APPLY, '0);
        dp_scale    = 32'(START_SCALE);
        dp_offset   = 32'(START_OFFSET);
        exp_info[4] = dp_scale;
        exp_info[5] = dp_offset;
    endtask

    task automatic serve_loop(input int k);
        logic [WB_DAT_W-1:0]  w [INFO_WORDS];
        logic [WB_DAT_W-1:0]  base;
        logic [WB_DAT_W-1:0]  spread;
        logic [WB_DAT_W-1:0]  extra;
        logic [31:0]          polls;
        logic [SCALE_W-1:0]   ns;
        logic [OFFSET_W-1:0]  no;
        serve_transfer("cmd_reset", 1'b1, ADR_CTRL, CMD_RESET, '0);
        serve_transfer("cmd_start", 1'b1, ADR_CTRL, CMD_START, '0);
        polls = rand_bits(2);
        repeat (polls) begin
            serve_transfer("status_poll", 1'b0, ADR_CTRL, '0,
                           rand_bits(32) & ~(32'd1 << DONE_BIT));
        end
        serve_transfer("status_poll", 1'b0, ADR_CTRL, '0, rand_bits(32) | (32'd1 << DONE_BIT));

        // Classes rotate with the loop index so every branch is reached
        w[0] = rand_bits(32);
        case ((k / 4) % 4)
            0:       w[1] = (32'd17 + rand_bits(6)) << RMS_SHIFT;   // Loud
            1:       w[1] = rand_bits(4) << RMS_SHIFT;              // Quiet
            2:       w[1] = TARGET_RMS_SQ << RMS_SHIFT;
            default: w[1] = (TARGET_RMS_SQ + 1) << RMS_SHIFT;
        endcase
        w[1]   = w[1] | rand_bits(RMS_SHIFT);
        base   = rand_bits(10);
        spread = rand_bits(3) % 6;                  // Dead band of 0 to OFFSET_ERR
        extra  = rand_bits(4);
        case (k % 3)
            0:       {w[2], w[3]} = {base + OFFSET_ERR + 1 + extra, base};
            1:       {w[2], w[3]} = {base, base + OFFSET_ERR + 1 + extra};
            default: {w[2], w[3]} = rand_bits(1) ? {base + spread, base} : {base, base + spread};
        endcase
        // Scale register sometimes reported at the cutoffs
        case (k % 4)
            0:       w[4] = SCALE_MIN - rand_bits(2);
            1:       w[4] = SCALE_MAX + rand_bits(2);
            default: w[4] = dp_scale;
        endcase
        w[5] = (k % 5 == 4) ? (32'hFFFF_8000 | rand_bits(4)) : dp_offset;   // Near wrap

        for (int i = 0; i < INFO_WORDS; i++) begin
            serve_transfer("stat_read", 1'b0, WB_ADR_W'(i * 4), '0, w[i]);
        end
        ns = model_scale(w[1], w[4]);
        no = model_offset(w[2], w[3], w[5]);
        dp_scale  = {15'h0, ns};
        dp_offset = {{16{no[15]}}, no};
        serve_transfer("scale_write", 1'b1, ADR_SCALE, dp_scale, '0);
        serve_transfer("offset_write", 1'b1, ADR_OFFSET, dp_offset, '0);
        serve_transfer("cmd_load", 1'b1, ADR_CTRL, CMD_LOAD, '0);
        serve_transfer("cmd_apply", 1'b1, ADR_CTRL, CMD_APPLY, '0);
        for (int i = 0; i < 4; i++) exp_info[i] = w[i];
        exp_info[4] = dp_scale;
        exp_info[5] = dp_offset;
        loops++;
    endtask

    task automatic reset_mid_loop();
        serve_transfer("cmd_reset", 1'b1, ADR_CTRL, CMD_RESET, '0);
        serve_transfer("cmd_start", 1'b1, ADR_CTRL, CMD_START, '0);
        agc_reset_i = 1'b1;
        @(negedge aclk);
        agc_reset_i = 1'b0;
        serve_start_values();
    endtask

    ////////////////////////////////////////////////////////////
    // Status slave accesses
    ////////////////////////////////////////////////////////////
    task automatic ctl_transfer(input string name, input logic we, input logic [WB_ADR_W-1:0] adr,
                                input logic [WB_DAT_W-1:0] wdat, input logic [WB_DAT_W-1:0] exp);
        wb_ctl_cyc_i = 1'b1;
        wb_ctl_stb_i = 1'b1;
        wb_ctl_we_i  = we;
        wb_ctl_adr_i = adr;
        wb_ctl_dat_i = wdat;
        @(negedge aclk);
        if (wb_ctl_ack_o !== 1'b0) begin
            errors++;
            $display("%s: ack came one edge after the request", name);
        end
        @(negedge aclk);
        if (wb_ctl_ack_o !== 1'b1) begin
            errors++;
            $display("%s: no ack two edges after the request", name);
        end else if (!we && wb_ctl_dat_o !== exp) begin
            report_mismatch(name, exp, wb_ctl_dat_o);
        end
        wb_ctl_cyc_i = 1'b0;                        // Drop before the ack edge
        wb_ctl_stb_i = 1'b0;
        wb_ctl_we_i  = 1'b0;
        @(negedge aclk);
        if (wb_ctl_ack_o !== 1'b0) begin
            errors++;
            $display("%s: ack stayed high for a second cycle", name);
        end
    endtask

    task automatic read_back_status();
        for (int i = 0; i < 8; i++) begin
            ctl_transfer("ctl_stat", 1'b0, WB_ADR_W'(i * 4), '0,
                         (i < INFO_WORDS) ? exp_info[i] : '0);
        end
        ctl_transfer("ctl_step", 1'b0, 8'd64, '0, 32'(SCALE_STEP));
        ctl_transfer("ctl_step", 1'b0, 8'd68, '0, 32'(OFFSET_STEP));
        ctl_transfer("ctl_step", 1'b0, 8'd72, '0, '0);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        lfsr         = 16'd20401;
        wb_rst_i     = 1'b1;
        agc_reset_i  = 1'b0;
        wb_ctl_cyc_i = 1'b0;
        wb_ctl_stb_i = 1'b0;
        wb_ctl_we_i  = 1'b0;
        wb_ctl_adr_i = '0;
        wb_ctl_dat_i = '0;
        wb_agc_ack_i = 1'b0;
        wb_agc_dat_i = '0;
        for (int b = 0; b < 8; b++) hits[b] = 0;
        repeat (4) @(negedge aclk);
        if (wb_agc_cyc_o !== 1'b0 || wb_agc_stb_o !== 1'b0 || wb_ctl_ack_o !== 1'b0) begin
            errors++;
            $display("Bus outputs are not low during reset");
        end
        wb_rst_i = 1'b0;
        serve_start_values();
        for (int k = 0; k < NUM_LOOPS; k++) begin
            if (k == RESET_LOOP) reset_mid_loop();
            serve_loop(k);
            if (k == 0) ctl_transfer("ctl_write", 1'b1, 8'd0, rand_bits(32), '0);  // Ignored
            read_back_status();
        end
        for (int b = 0; b < 8; b++) begin
            if (hits[b] == 0) begin
                errors++;
                $display("Step rule branch %0d was never exercised", b);
            end
        end
        $display("Loops: %0d, transfers: %0d, errors: %0d", loops, transfers, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);             // Twice the worst-case run
        $display("Watchdog expired before the test sequence finished");
        $display("Loops: %0d, transfers: %0d, errors: %0d", loops, transfers, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== design/agc_loop_top.sv ====
`timescale 1ns/1ps

module agc_loop_top import agc_loop_pkg::*; (
    input  logic                aclk,
    input  logic                wb_rst_i,
    input  logic                agc_reset_i,
    // Control port
    input  logic                wb_ctl_cyc_i,
    input  logic                wb_ctl_stb_i,
    input  logic                wb_ctl_we_i,
    input  logic [WB_ADR_W-1:0] wb_ctl_adr_i,
    input  logic [WB_DAT_W-1:0] wb_ctl_dat_i,
    output logic                wb_ctl_ack_o,
    output logic [WB_DAT_W-1:0] wb_ctl_dat_o,
    // AGC datapath port
    output logic                wb_agc_cyc_o,
    output logic                wb_agc_stb_o,
    output logic                wb_agc_we_o,
    output logic [WB_ADR_W-1:0] wb_agc_adr_o,
    output logic [WB_DAT_W-1:0] wb_agc_dat_o,
    input  logic                wb_agc_ack_i,
    input  logic [WB_DAT_W-1:0] wb_agc_dat_i
);

    logic                                 req;
    logic                                 req_we;
    logic [WB_ADR_W-1:0]                  req_adr;
    logic [WB_DAT_W-1:0]                  req_dat;
    logic                                 done;
    logic [WB_DAT_W-1:0]                  rd_dat;
    logic [INFO_WORDS-1:0][WB_DAT_W-1:0]  info;
    logic [SCALE_W-1:0]                   next_scale;
    logic signed [OFFSET_W-1:0]           next_offset;

    agc_sequencer u_sequencer (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_reset_i   (agc_reset_i),
        .done_i        (done),
        .rd_dat_i      (rd_dat),
        .next_scale_i  (next_scale),
        .next_offset_i (next_offset),
        .req_o         (req),
        .req_we_o      (req_we),
        .req_adr_o     (req_adr),
        .req_dat_o     (req_dat),
        .info_o        (info)
    );

    agc_wb_master u_master (
        .aclk         (aclk),
        .wb_rst_i     (wb_rst_i),
        .req_i        (req),
        .req_we_i     (req_we),
        .req_adr_i    (req_adr),
        .req_dat_i    (req_dat),
        .done_o       (done),
        .rd_dat_o     (rd_dat),
        .wb_agc_cyc_o (wb_agc_cyc_o),
        .wb_agc_stb_o (wb_agc_stb_o),
        .wb_agc_we_o  (wb_agc_we_o),
        .wb_agc_adr_o (wb_agc_adr_o),
        .wb_agc_dat_o (wb_agc_dat_o),
        .wb_agc_ack_i (wb_agc_ack_i),
        .wb_agc_dat_i (wb_agc_dat_i)
    );

    agc_step_calc u_step_calc (
        .info_i        (info),
        .next_scale_o  (next_scale),
        .next_offset_o (next_offset)
    );

    agc_status_slave u_status (
        .aclk         (aclk),
        .wb_rst_i     (wb_rst_i),
        .wb_ctl_cyc_i (wb_ctl_cyc_i),
        .wb_ctl_stb_i (wb_ctl_stb_i),
        .wb_ctl_we_i  (wb_ctl_we_i),
        .wb_ctl_adr_i (wb_ctl_adr_i),
        .wb_ctl_dat_i (wb_ctl_dat_i),
        .info_i       (info),
        .wb_ctl_ack_o (wb_ctl_ack_o),
        .wb_ctl_dat_o (wb_ctl_dat_o)
    );

endmodule

// ==== design/agc_status_slave.sv ====
`timescale 1ns/1ps

module agc_status_slave import agc_loop_pkg::*; (
    input  logic                                aclk,
    input  logic                                wb_rst_i,
    input  logic                                wb_ctl_cyc_i,
    input  logic                                wb_ctl_stb_i,
    input  logic                                wb_ctl_we_i,
    input  logic [WB_ADR_W-1:0]                 wb_ctl_adr_i,
    input  logic [WB_DAT_W-1:0]                 wb_ctl_dat_i,
    input  logic [INFO_WORDS-1:0][WB_DAT_W-1:0] info_i,
    output logic                                wb_ctl_ack_o,
    output logic [WB_DAT_W-1:0]                 wb_ctl_dat_o
);

    ctl_state_e  state;
    logic [3:0]  sel_idx;                           // Word index from address bits 5:2

    assign sel_idx      = wb_ctl_adr_i[5:2];
    assign wb_ctl_ack_o = (state == CTL_ACK);

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state <= CTL_IDLE;
        end else begin
            case (state)
                CTL_IDLE: begin
                    if (wb_ctl_cyc_i && wb_ctl_stb_i) state <= wb_ctl_we_i ? CTL_WRITE : CTL_READ;
                end
                CTL_WRITE: state <= CTL_ACK;        // Nothing writable, ack only
                CTL_READ:  state <= CTL_ACK;
                default:   state <= CTL_IDLE;
            endcase
        end
    end

    // Registered read response
    always_ff @(posedge aclk) begin
        if (state == CTL_READ) begin
            wb_ctl_dat_o <= '0;
            if (wb_ctl_adr_i[ADR_LOOP_SEL]) begin   // Loop step sizes
                if (sel_idx == 4'd0) wb_ctl_dat_o <= {{(WB_DAT_W-SCALE_W){1'b0}}, SCALE_STEP};
                if (sel_idx == 4'd1) begin
                    wb_ctl_dat_o <= {{(WB_DAT_W-OFFSET_W){OFFSET_STEP[OFFSET_W-1]}}, OFFSET_STEP};
                end
            end else if (sel_idx < 4'(INFO_WORDS)) begin
                wb_ctl_dat_o <= info_i[sel_idx[INFO_IDX_W-1:0]];
            end
        end
    end

    a_ack_single: assert property (@(posedge aclk) disable iff (wb_rst_i)
        wb_ctl_ack_o |=> !wb_ctl_ack_o);

endmodule

// ==== design/agc_sequencer.sv ====
`timescale 1ns/1ps

module agc_sequencer import agc_loop_pkg::*; (
    input  logic                                aclk,
    input  logic                                wb_rst_i,
    input  logic                                agc_reset_i,
    input  logic                                done_i,
    input  logic [WB_DAT_W-1:0]                 rd_dat_i,
    input  logic [SCALE_W-1:0]                  next_scale_i,
    input  logic signed [OFFSET_W-1:0]          next_offset_i,
    output logic                                req_o,
    output logic                                req_we_o,
    output logic [WB_ADR_W-1:0]                 req_adr_o,
    output logic [WB_DAT_W-1:0]                 req_dat_o,
    output logic [INFO_WORDS-1:0][WB_DAT_W-1:0] info_o
);

    loop_state_e                state;
    logic [BOOT_CNT_W-1:0]      boot_cnt;
    logic [INFO_IDX_W-1:0]      idx;                // Statistics word being read
    logic [SCALE_W-1:0]         scale_q;
    logic signed [OFFSET_W-1:0] offset_q;
    logic                       busy;               // Request outstanding at the master
    logic                       fin;

    assign fin = busy && done_i;

    ////////////////////////////////////////////////////////////
    // Request decode held for the whole state
    ////////////////////////////////////////////////////////////
    always_comb begin
        req_we_o  = 1'b1;
        req_adr_o = ADR_CTRL;
        req_dat_o = '0;
        case (state)
            WRITING_SCALE: begin
                req_adr_o = ADR_SCALE;
                req_dat_o = {{(WB_DAT_W-SCALE_W){1'b0}}, scale_q};
            end
            WRITING_OFFSET: begin
                req_adr_o = ADR_OFFSET;
                req_dat_o = {{(WB_DAT_W-OFFSET_W){offset_q[OFFSET_W-1]}}, offset_q};
            end
            LOADING:   req_dat_o = CMD_LOAD;
            APPLYING:  req_dat_o = CMD_APPLY;
            RESETTING: req_dat_o = CMD_RESET;
            POLLING:   req_dat_o = CMD_START;
            WAITING:   req_we_o  = 1'b0;            // Status poll
            READING: begin
                req_we_o  = 1'b0;
                req_adr_o = {{(WB_ADR_W-INFO_IDX_W-2){1'b0}}, idx, 2'b00};
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Loop FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state    <= BOOTING;
            boot_cnt <= BOOT_CNT_W'(BOOT_DELAY);
            idx      <= '0;
            scale_q  <= START_SCALE;
            offset_q <= START_OFFSET;
            busy     <= 1'b0;
            req_o    <= 1'b0;
        end else begin
            req_o <= 1'b0;
            case (state)
                BOOTING: begin
                    if (boot_cnt != '0) boot_cnt <= boot_cnt - 1'b1;
                    else state <= WRITING_SCALE;    // Push the start values first
                end
                CALCULATING: begin
                    scale_q  <= next_scale_i;
                    offset_q <= next_offset_i;
                    state    <= WRITING_SCALE;
                end
                default: begin
                    if (!busy) begin
                        req_o <= 1'b1;
                        busy  <= 1'b1;
                    end else if (done_i) begin
                        busy <= 1'b0;
                        case (state)
                            WRITING_SCALE:  state <= WRITING_OFFSET;
                            WRITING_OFFSET: state <= LOADING;
                            LOADING:        state <= APPLYING;
                            APPLYING:       state <= RESETTING;
                            RESETTING:      state <= POLLING;
                            POLLING:        state <= WAITING;
                            WAITING: begin          // Poll again unless done
                                if (rd_dat_i[DONE_BIT]) begin
                                    state <= READING;
                                    idx   <= '0;
                                end
                            end
                            READING: begin
                                if (idx == INFO_IDX_W'(INFO_WORDS - 1)) begin
                                    state <= CALCULATING;
                                    idx   <= '0;
                                end else begin
                                    idx <= idx + 1'b1;
                                end
                            end
                            default: state <= BOOTING;
                        endcase
                    end
                end
            endcase
        end
    end

    // Statistics store with scale and offset refreshed once applied
    always_ff @(posedge aclk) begin
        if (fin && state == READING) info_o[idx] <= rd_dat_i;
        if (fin && state == APPLYING) begin
            info_o[4] <= {{(WB_DAT_W-SCALE_W){1'b0}}, scale_q};
            info_o[5] <= {{(WB_DAT_W-OFFSET_W){offset_q[OFFSET_W-1]}}, offset_q};
        end
    end

    // One transfer at a time toward the master
    a_one_outstanding: assert property (@(posedge aclk)
        disable iff (wb_rst_i || agc_reset_i)
        req_o |=> (!req_o until_with done_i));

endmodule

// ==== design/agc_wb_master.sv ====
`timescale 1ns/1ps

module agc_wb_master import agc_loop_pkg::*; (
    input  logic                aclk,
    input  logic                wb_rst_i,
    // Request side
    input  logic                req_i,
    input  logic                req_we_i,
    input  logic [WB_ADR_W-1:0] req_adr_i,
    input  logic [WB_DAT_W-1:0] req_dat_i,
    output logic                done_o,
    output logic [WB_DAT_W-1:0] rd_dat_o,
    // Wishbone classic master
    output logic                wb_agc_cyc_o,
    output logic                wb_agc_stb_o,
    output logic                wb_agc_we_o,
    output logic [WB_ADR_W-1:0] wb_agc_adr_o,
    output logic [WB_DAT_W-1:0] wb_agc_dat_o,
    input  logic                wb_agc_ack_i,
    input  logic [WB_DAT_W-1:0] wb_agc_dat_i
);

    logic cyc_q;                                    // Busy while high
    logic stb_q;

    assign wb_agc_cyc_o = cyc_q;
    assign wb_agc_stb_o = stb_q;

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            cyc_q        <= 1'b0;
            stb_q        <= 1'b0;
            done_o       <= 1'b0;
            wb_agc_we_o  <= 1'b0;
            wb_agc_adr_o <= '0;
            wb_agc_dat_o <= '0;
        end else begin
            done_o <= 1'b0;
            if (!cyc_q) begin
                if (req_i) begin                    // Put request on the bus
                    cyc_q        <= 1'b1;
                    stb_q        <= 1'b1;
                    wb_agc_we_o  <= req_we_i;
                    wb_agc_adr_o <= req_adr_i;
                    wb_agc_dat_o <= req_dat_i;
                end
            end else if (wb_agc_ack_i) begin        // Late ack just stretches the cycle
                cyc_q        <= 1'b0;
                stb_q        <= 1'b0;
                done_o       <= 1'b1;
                wb_agc_we_o  <= 1'b0;
                wb_agc_adr_o <= '0;
                wb_agc_dat_o <= '0;
            end
        end
    end

    // Read data capture
    always_ff @(posedge aclk) begin
        if (cyc_q && wb_agc_ack_i) rd_dat_o <= wb_agc_dat_i;
    end

    a_stb_in_cyc: assert property (@(posedge aclk) disable iff (wb_rst_i)
        wb_agc_stb_o |-> wb_agc_cyc_o);

    a_hold_until_ack: assert property (@(posedge aclk) disable iff (wb_rst_i)
        wb_agc_stb_o && !wb_agc_ack_i |=> wb_agc_stb_o && $stable(wb_agc_we_o)
            && $stable(wb_agc_adr_o) && $stable(wb_agc_dat_o));

endmodule

// ==== design/agc_step_calc.sv ====
`timescale 1ns/1ps

module agc_step_calc import agc_loop_pkg::*; (
    input  logic [INFO_WORDS-1:0][WB_DAT_W-1:0] info_i,
    output logic [SCALE_W-1:0]                  next_scale_o,
    output logic signed [OFFSET_W-1:0]          next_offset_o
);

    logic [WB_DAT_W-1:0]        rms_adj;            // Mean square at the target timescale
    logic [SCALE_W-1:0]         scale_cur;
    logic signed [OFFSET_W-1:0] offset_cur;
    logic [WB_DAT_W-1:0]        n_above;
    logic [WB_DAT_W-1:0]        n_below;

    assign rms_adj    = info_i[1] >> RMS_SHIFT;
    assign n_above    = info_i[2];
    assign n_below    = info_i[3];
    assign scale_cur  = info_i[4][SCALE_W-1:0];
    assign offset_cur = info_i[5][OFFSET_W-1:0];

    ////////////////////////////////////////////////////////////
    // Scale, fixed step toward the target with cutoffs
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_scale_o = scale_cur;
        if (rms_adj > TARGET_RMS_SQ + RMS_SQ_ERR) begin
            if (scale_cur > SCALE_MIN) next_scale_o = scale_cur - SCALE_STEP;  // Too loud
        end else if (rms_adj < TARGET_RMS_SQ - RMS_SQ_ERR) begin
            if (scale_cur < SCALE_MAX) next_scale_o = scale_cur + SCALE_STEP;  // Too quiet
        end
    end

    ////////////////////////////////////////////////////////////
    // Offset, balance the counts above and below
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_offset_o = offset_cur;
        if (n_above > n_below + OFFSET_ERR) begin
            next_offset_o = offset_cur - OFFSET_STEP;
        end else if (n_below > n_above + OFFSET_ERR) begin
            next_offset_o = offset_cur + OFFSET_STEP;
        end
        // Inside the dead band the offset holds
    end

endmodule

// ==== design/agc_loop_pkg.sv ====
package agc_loop_pkg;

    ////////////////////////////////////////////////////////////
    // Bus and datapath widths
    ////////////////////////////////////////////////////////////
    localparam int WB_ADR_W   = 8;
    localparam int WB_DAT_W   = 32;
    localparam int SCALE_W    = 17;
    localparam int OFFSET_W   = 16;                 // Signed
    localparam int INFO_WORDS = 6;
    localparam int INFO_IDX_W = 3;

    ////////////////////////////////////////////////////////////
    // Control loop constants
    ////////////////////////////////////////////////////////////
    localparam int BOOT_DELAY = 31;
    localparam int BOOT_CNT_W = $clog2(BOOT_DELAY + 1);

    localparam logic        [SCALE_W-1:0]  START_SCALE  = 17'd1500;
    localparam logic signed [OFFSET_W-1:0] START_OFFSET = 16'sd0;
    localparam logic        [SCALE_W-1:0]  SCALE_STEP   = 17'd30;
    localparam logic signed [OFFSET_W-1:0] OFFSET_STEP  = 16'sd25;
    localparam logic        [SCALE_W-1:0]  SCALE_MIN    = 17'd300;    // Lower cutoff
    localparam logic        [SCALE_W-1:0]  SCALE_MAX    = 17'd130000; // Upper cutoff

    localparam logic [WB_DAT_W-1:0] TARGET_RMS_SQ = 32'd16;
    localparam logic [WB_DAT_W-1:0] RMS_SQ_ERR    = 32'd0;
    localparam logic [WB_DAT_W-1:0] OFFSET_ERR    = 32'd5;

    localparam int RMS_SHIFT = 17 - 4;              // Timescale reduction of 4 bits
    localparam int DONE_BIT  = 1;                   // Sample period finished

    // AGC datapath register map
    localparam logic [WB_ADR_W-1:0] ADR_CTRL   = 8'd0;
    localparam logic [WB_ADR_W-1:0] ADR_SCALE  = 8'd16;
    localparam logic [WB_ADR_W-1:0] ADR_OFFSET = 8'd20;

    localparam int ADR_LOOP_SEL = 6;                // Slave side, loop params vs statistics

    // Statistics words: status, mean square, above, below, scale, offset

    typedef enum logic [WB_DAT_W-1:0] {
        CMD_START = 32'd1,
        CMD_RESET = 32'd4,
        CMD_LOAD  = 32'd768,
        CMD_APPLY = 32'd1024
    } agc_cmd_e;

    typedef enum logic [3:0] {
        BOOTING,                                    // Counts down BOOT_DELAY
        RESETTING, POLLING, WAITING, READING, CALCULATING,
        WRITING_SCALE, WRITING_OFFSET, LOADING, APPLYING
    } loop_state_e;

    typedef enum logic [1:0] {CTL_IDLE, CTL_WRITE, CTL_READ, CTL_ACK} ctl_state_e;

endpackage
